// File: logic/cache_pkg.sv
`default_nettype none

package cache_pkg;

  //////////////////////////////
  // Cache geometry
  //////////////////////////////
  localparam int addr_w         = 16;  // Byte address from the CPU.
  localparam int data_w         = 16;  // One word of the data array.
  localparam int tag_w          = 6;   // Upper address bits kept per way.
  localparam int index_w        = 6;   // Selects one of the sets.
  localparam int num_sets       = 64;
  localparam int words_per_line = 8;   // A line covers 16 bytes.
  localparam int mem_latency    = 4;   // Cycles from mem_en to mem_data_valid.

  // Derived field widths of an address.
  localparam int word_w   = $clog2(words_per_line);    // Word select inside a line.
  localparam int offset_w = addr_w - tag_w - index_w;  // Byte offset, 4 bits here.

  //////////////////////////////
  // Bundles between the blocks
  //////////////////////////////
  typedef struct packed {
    logic              valid;  // The CPU wants a read this cycle.
    logic [addr_w-1:0] addr;
  } cpu_req_t;

  typedef struct packed {
    logic [tag_w-1:0] tag;
    logic             valid;
    logic             lru;    // Set when this way is the next one to replace.
  } tag_entry_t;

  typedef struct packed {
    logic              miss;        // Lookup failed and no fill is running.
    logic [addr_w-1:0] addr;
    logic              victim_way;  // Way that the fill will overwrite.
  } miss_info_t;

  typedef struct packed {
    logic               data_we;  // Write one word of the data array.
    logic               tag_we;   // Write the tag entry, on the last word only.
    logic               way;
    logic [index_w-1:0] index;
    logic [word_w-1:0]  word;
    logic [data_w-1:0]  data;
    tag_entry_t         tag;
  } fill_wr_t;

  // States of the miss-fill controller.
  typedef enum logic [1:0] {
    fill_idle,  // Waiting for a miss.
    fill_wait,  // Waiting for the memory grant.
    fill_send   // Sending addresses and collecting words.
  } fill_state_e;

endpackage

`default_nettype wire

// File: logic/tag_lookup.sv
`timescale 1ns/100ps
`default_nettype none

module tag_lookup import cache_pkg::*; (
  input  wire           clk,      // Cache clock.
  input  wire           arst_n,   // Asynchronous reset, active low.
  input  wire cpu_req_t req,      // Read request, held by the CPU during a stall.
  input  wire           busy,     // A fill is in progress.
  input  wire fill_wr_t fill,     // Tag write from the fill controller.
  output logic          hit,      // Request found in one of the ways.
  output logic          hit_way,  // Way that holds the requested line.
  output miss_info_t    miss      // Miss report to the fill controller.
);

  // Two tag entries per set, one for each way.
  tag_entry_t tag_mem [2][num_sets];

  logic [index_w-1:0] req_index;   // Set addressed by the request.
  logic [tag_w-1:0]   req_tag;     // Tag bits of the request.
  tag_entry_t         way0_entry;  // Entries of the addressed set.
  tag_entry_t         way1_entry;
  logic [1:0]         way_hit;     // One match flag per way.
  logic               victim;      // Way chosen for replacement.

  //////////////////////////////
  // Lookup
  //////////////////////////////
  assign req_index  = req.addr[offset_w +: index_w];
  assign req_tag    = req.addr[addr_w-1 -: tag_w];
  assign way0_entry = tag_mem[0][req_index];
  assign way1_entry = tag_mem[1][req_index];

  // A way matches only when its entry is valid and the stored tag is equal.
  assign way_hit[0] = req.valid && way0_entry.valid && (way0_entry.tag == req_tag);
  assign way_hit[1] = req.valid && way1_entry.valid && (way1_entry.tag == req_tag);

  assign hit     = |way_hit;
  assign hit_way = way_hit[1];  // Way 0 whenever way 1 does not match.

  // An empty way is filled first. With both ways valid the LRU bit decides.
  always_comb begin
    if (!way0_entry.valid) begin
      victim = 1'b0;
    end else if (!way1_entry.valid) begin
      victim = 1'b1;
    end else begin
      victim = way1_entry.lru;  // Way 1 goes when its LRU bit is set, else way 0.
    end
  end

  // The held request keeps missing during a fill, so it is blanked until busy drops.
  always_comb begin
    miss.miss       = req.valid && !hit && !busy;
    miss.addr       = req.addr;
    miss.victim_way = victim;
  end

  //////////////////////////////
  // Tag and LRU update
  //////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int s = 0; s < num_sets; s++) begin
        tag_mem[0][s] <= '0;  // Every line starts invalid.
        tag_mem[1][s] <= '0;
      end
    end else if (fill.tag_we) begin
      tag_mem[fill.way][fill.index]      <= fill.tag;  // New line, valid and recent.
      tag_mem[!fill.way][fill.index].lru <= 1'b1;      // The other way ages.
    end else if (hit) begin
      tag_mem[hit_way][req_index].lru  <= 1'b0;
      tag_mem[!hit_way][req_index].lru <= 1'b1;
    end
  end

  // The fill controller only writes a tag that missed in both ways of its set,
  // so a set never holds the same valid tag twice.
  assert property (@(posedge clk) disable iff (!arst_n) !(way_hit[0] && way_hit[1]))
    else $error("Both ways hit for address %h.", req.addr);

endmodule

`default_nettype wire

// File: logic/miss_fill_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module miss_fill_ctrl import cache_pkg::*; (
  input  wire               clk,             // Cache clock.
  input  wire               arst_n,          // Asynchronous reset, active low.
  input  wire miss_info_t   miss,            // Miss report from the lookup.
  input  wire               grant,           // Memory access granted, held as a level.
  input  wire [data_w-1:0]  mem_data,        // Word returning from memory.
  input  wire               mem_data_valid,  // mem_data holds a word this cycle.
  output logic              busy,            // Stalls the CPU while the line is filled.
  output logic              mem_en,          // Memory read enable, one word per cycle.
  output logic [addr_w-1:0] mem_addr,        // Address sent to memory.
  output fill_wr_t          fill             // Writes into the tag and data arrays.
);

  fill_state_e state;      // Current state.
  fill_state_e state_nxt;  // State after the next edge.

  logic [3:0]        valid_cnt;   // Words returned so far.
  logic [addr_w-1:0] line_base;   // First byte of the line being filled.
  logic              victim_way;  // Way that receives the line.

  // mem_addr delayed by mem_latency cycles, so that the last stage lines up
  // with the word that memory returns for it.
  logic [addr_w-1:0] addr_pipe [mem_latency];

  logic capture;     // Take the miss address and victim way.
  logic incr_addr;   // Step mem_addr to the next word.
  logic set_busy;
  logic clr_busy;
  logic set_mem_en;
  logic clr_mem_en;
  logic data_we;     // Write the returning word.
  logic tag_we;      // Write the tag with the last word.
  logic addr_last;   // mem_addr holds the last word of the line.
  logic word7;       // Seven words are already in the data array.

  assign addr_last = mem_addr[offset_w-1:0] == offset_w'(2 * (words_per_line - 1));
  assign word7     = valid_cnt == 4'(words_per_line - 1);

  //////////////////////////////
  // Next-state and strobes
  //////////////////////////////
  always_comb begin
    state_nxt  = state;  // Hold by default.
    capture    = 1'b0;
    set_busy   = 1'b0;
    clr_busy   = 1'b0;
    set_mem_en = 1'b0;
    clr_mem_en = 1'b0;
    incr_addr  = 1'b0;
    data_we    = 1'b0;
    tag_we     = 1'b0;
    case (state)
      fill_idle: begin
        capture  = miss.miss;  // Line base, victim and counter are loaded together.
        set_busy = miss.miss;
        if (miss.miss) begin
          state_nxt = fill_wait;
        end
      end
      fill_wait: begin
        set_mem_en = grant;  // No limit on the wait. mem_en stays low meanwhile.
        if (grant) begin
          state_nxt = fill_send;
        end
      end
      fill_send: begin
        incr_addr  = mem_en && !addr_last;  // The address parks on the last word.
        clr_mem_en = mem_en && addr_last;   // Eight addresses, then memory is idle.
        data_we    = mem_data_valid && (valid_cnt < 4'(words_per_line));
        tag_we     = data_we && word7;      // The eighth word completes the line.
        clr_busy   = tag_we;
        if (tag_we) begin
          state_nxt = fill_idle;
        end
      end
      default: begin
        state_nxt  = fill_idle;  // An illegal encoding drops back to idle.
        clr_busy   = 1'b1;
        clr_mem_en = 1'b1;
      end
    endcase
  end

  //////////////////////////////
  // Control registers
  //////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= fill_idle;
      busy      <= 1'b0;
      mem_en    <= 1'b0;
      valid_cnt <= '0;
    end else begin
      state <= state_nxt;
      if (set_busy) begin
        busy <= 1'b1;
      end else if (clr_busy) begin
        busy <= 1'b0;
      end
      if (set_mem_en) begin
        mem_en <= 1'b1;
      end else if (clr_mem_en) begin
        mem_en <= 1'b0;
      end
      if (capture) begin
        valid_cnt <= '0;
      end else if (data_we) begin
        valid_cnt <= valid_cnt + 4'd1;  // Counts written words.
      end
    end
  end

  // Address generator. Each word is two bytes apart.
  always_ff @(posedge clk) begin
    if (capture) begin
      line_base  <= {miss.addr[addr_w-1:offset_w], {offset_w{1'b0}}};
      mem_addr   <= {miss.addr[addr_w-1:offset_w], {offset_w{1'b0}}};
      victim_way <= miss.victim_way;
    end else if (incr_addr) begin
      mem_addr <= mem_addr + addr_w'(2);
    end
  end

  // Latency chain.
  always_ff @(posedge clk) begin
    addr_pipe[0] <= mem_addr;
    for (int i = 1; i < mem_latency; i++) begin
      addr_pipe[i] <= addr_pipe[i-1];
    end
  end

  //////////////////////////////
  // Writes into the arrays
  //////////////////////////////
  always_comb begin
    fill.data_we   = data_we;
    fill.tag_we    = tag_we;
    fill.way       = victim_way;
    fill.index     = addr_pipe[mem_latency-1][offset_w +: index_w];
    fill.word      = addr_pipe[mem_latency-1][1 +: word_w];  // Bit 0 is the byte.
    fill.data      = mem_data;
    fill.tag.tag   = line_base[addr_w-1 -: tag_w];
    fill.tag.valid = 1'b1;  // The new line becomes valid.
    fill.tag.lru   = 1'b0;  // And most recently used.
  end

  // Data writes belong to a running fill.
  assert property (@(posedge clk) disable iff (!arst_n) fill.data_we |-> busy)
    else $error("Data array written outside a fill.");

  // A burst is never longer than one line.
  assert property (@(posedge clk) disable iff (!arst_n)
    $rose(mem_en) |-> ##words_per_line !mem_en)
    else $error("mem_en held past %0d cycles.", words_per_line);

  // Every address sent belongs to the line that missed.
  assert property (@(posedge clk) disable iff (!arst_n)
    mem_en |-> mem_addr[addr_w-1:offset_w] == line_base[addr_w-1:offset_w])
    else $error("mem_addr %h left the line at %h.", mem_addr, line_base);

endmodule

`default_nettype wire

// File: logic/line_store.sv
`timescale 1ns/100ps
`default_nettype none

module line_store import cache_pkg::*; (
  input  wire               clk,      // Cache clock.
  input  wire fill_wr_t     fill,     // Word writes from the fill controller.
  input  wire [addr_w-1:0]  addr,     // Address of the CPU read.
  input  wire               way,      // Way that hit.
  output logic [data_w-1:0] rd_data   // Word selected by addr in that way.
);

  //////////////////////////////
  // Data array
  //////////////////////////////
  // Two ways of 64 lines, each line eight words wide.
  logic [data_w-1:0] data_mem [2][num_sets][words_per_line];

  logic [index_w-1:0] rd_index;  // Set of the read.
  logic [word_w-1:0]  rd_word;   // Word inside the line.

  // The index sits right above the byte offset.
  assign rd_index = addr[offset_w +: index_w];

  // Words are two bytes wide, so bit 0 only picks a byte and plays no part here.
  assign rd_word = addr[1 +: word_w];

  // One word per cycle comes in while a line is filled.
  always_ff @(posedge clk) begin
    if (fill.data_we) begin
      data_mem[fill.way][fill.index][fill.word] <= fill.data;
    end
  end

  //////////////////////////////
  // Read port
  //////////////////////////////
  // The read is combinational. On a miss the word is don't-care, since the
  // CPU is stalled until the line is in place.
  assign rd_data = data_mem[way][rd_index][rd_word];

  // The word index comes out of the latency chain. An unknown value there
  // means the chain was not filled from a real address before the write.
  assert property (@(posedge clk) fill.data_we |-> !$isunknown(fill.word))
    else $error("Data write with unknown word index.");

  // The same holds for the set index and the way.
  assert property (@(posedge clk) fill.data_we |-> !$isunknown({fill.way, fill.index}))
    else $error("Data write with unknown set or way.");

endmodule

`default_nettype wire

// File: logic/cache_top.sv
`timescale 1ns/100ps
`default_nettype none

module cache_top import cache_pkg::*; (
  input  wire               clk,             // Cache clock.
  input  wire               arst_n,          // Asynchronous reset, active low.
  // CPU side.
  input  wire cpu_req_t     req,             // Read request, held while stall is high.
  output logic              hit,             // rd_data is valid this cycle.
  output logic [data_w-1:0] rd_data,         // Word read from the cache.
  output logic              stall,           // A line fill is running.
  // Memory side.
  output logic              mem_en,          // Read enable to memory.
  output logic [addr_w-1:0] mem_addr,        // Word address to memory.
  input  wire               mem_grant,       // Memory access granted.
  input  wire [data_w-1:0]  mem_data,        // Word from memory.
  input  wire               mem_data_valid   // mem_data is valid.
);

  logic       hit_way;  // Way that holds the requested line.
  logic       busy;     // Fill in progress.
  miss_info_t miss;     // Lookup to controller.
  fill_wr_t   fill;     // Controller to both arrays.

  //////////////////////////////
  // Blocks
  //////////////////////////////
  tag_lookup u_tag_lookup (
    .clk     (clk),
    .arst_n  (arst_n),
    .req     (req),
    .busy    (busy),
    .fill    (fill),      // Only the tag fields are used here.
    .hit     (hit),
    .hit_way (hit_way),
    .miss    (miss)
  );

  miss_fill_ctrl u_miss_fill_ctrl (
    .clk            (clk),
    .arst_n         (arst_n),
    .miss           (miss),
    .grant          (mem_grant),
    .mem_data       (mem_data),
    .mem_data_valid (mem_data_valid),
    .busy           (busy),
    .mem_en         (mem_en),
    .mem_addr       (mem_addr),
    .fill           (fill)
  );

  line_store u_line_store (
    .clk     (clk),
    .fill    (fill),      // The data fields write the array.
    .addr    (req.addr),
    .way     (hit_way),
    .rd_data (rd_data)
  );

  // The CPU waits exactly as long as the controller is busy.
  assign stall = busy;

endmodule

`default_nettype wire

// File: dv/cache_tb.sv
`timescale 1ns/100ps
`default_nettype none

module cache_tb import cache_pkg::*; ();

  localparam int wait_limit = 100;  // Cycles that any single wait may take.

  logic              clk;
  logic              arst_n;
  cpu_req_t          req;
  logic              hit;
  logic [data_w-1:0] rd_data;
  logic              stall;
  logic              mem_en;
  logic [addr_w-1:0] mem_addr;
  logic              mem_grant;
  logic [data_w-1:0] mem_data;
  logic              mem_data_valid;

  logic [addr_w:0]   mem_q [$];  // One {en, addr} entry per cycle, waiting for its reply.
  int                grant_delay;  // Cycles of stall before the grant rises.
  logic              pred_valid;  // The request cycle is being checked.
  logic              pred_hit;    // Outcome that the model expects.
  logic [3:0]        en_run;      // Length of the current mem_en burst.

  // Reference model of the tag array. The LRU way is kept per set.
  logic [tag_w-1:0]  ref_tag [num_sets][2];
  logic              ref_valid [num_sets][2];
  logic              ref_lru_way [num_sets];

  cache_top u_dut (
    .clk            (clk),
    .arst_n         (arst_n),
    .req            (req),
    .hit            (hit),
    .rd_data        (rd_data),
    .stall          (stall),
    .mem_en         (mem_en),
    .mem_addr       (mem_addr),
    .mem_grant      (mem_grant),
    .mem_data       (mem_data),
    .mem_data_valid (mem_data_valid)
  );

  //////////////////////////////
  // Helpers
  //////////////////////////////
  // Memory contents. Every address bit feeds the word.
  function automatic logic [data_w-1:0] mem_word(input logic [addr_w-1:0] a);
    return {a[7:0], a[15:8]} ^ (a * 16'd29) ^ 16'hc35a;
  endfunction

  function automatic logic [addr_w-1:0] line_addr(input logic [tag_w-1:0] tag,
                                                  input logic [index_w-1:0] set,
                                                  input logic [word_w-1:0] word);
    return {tag, set, word, 1'b0};  // Word aligned.
  endfunction

  task automatic report_mismatch(input string what);
    $display("Fail %0t: %s", $time, what);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic abort_on_timeout(input string what);
    $display("Timeout at %0t: %s", $time, what);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  // One CPU read. The model predicts hit or miss and is updated the same way.
  task automatic do_read(input logic [addr_w-1:0] addr);
    logic [index_w-1:0] set;
    logic [tag_w-1:0]   tag;
    logic               way;
    logic               found;
    int                 waited;
    set   = addr[offset_w +: index_w];
    tag   = addr[addr_w-1 -: tag_w];
    found = 1'b0;
    way   = 1'b0;
    for (int w = 0; w < 2; w++) begin
      if (ref_valid[set][w] && ref_tag[set][w] == tag) begin
        found = 1'b1;
        way   = w[0];
      end
    end
    if (!found) begin  // An empty way first, else the least recently used one.
      if (!ref_valid[set][0]) way = 1'b0;
      else if (!ref_valid[set][1]) way = 1'b1;
      else way = ref_lru_way[set];
      ref_valid[set][way] = 1'b1;
      ref_tag[set][way]   = tag;
    end
    ref_lru_way[set] = !way;  // The way just used is the most recent.
    req.valid  = 1'b1;
    req.addr   = addr;
    pred_valid = 1'b1;
    pred_hit   = found;
    @(posedge clk);
    #1;
    pred_valid = 1'b0;
    waited     = 0;
    while (stall && waited < wait_limit) begin  // Request is held for the fill.
      waited++;
      @(posedge clk);
      #1;
    end
    if (stall) begin
      abort_on_timeout("stall did not fall after a miss");
    end else begin
      @(posedge clk);  // The held request is presented once more, now as a hit.
      #1;
    end
  endtask

  //////////////////////////////
  // Clock and memory model
  //////////////////////////////
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Words return mem_latency cycles after their mem_en cycle.
  initial begin : memory_model
    logic [addr_w:0] head;
    int              grant_wait;
    mem_grant      = 1'b0;
    mem_data       = '0;
    mem_data_valid = 1'b0;
    grant_wait     = 0;
    forever begin
      @(posedge clk);
      #1;
      mem_q.push_back({mem_en, mem_addr});
      if (mem_q.size() > mem_latency) begin
        head           = mem_q.pop_front();
        mem_data_valid = head[addr_w];
        mem_data       = head[addr_w] ? mem_word(head[addr_w-1:0]) : '0;
      end
      if (!stall) begin  // Grant is a level that drops with stall.
        mem_grant  = 1'b0;
        grant_wait = 0;
      end else if (!mem_grant) begin
        if (grant_wait >= grant_delay) mem_grant = 1'b1;
        else grant_wait++;
      end
    end
  end

  always @(posedge clk) begin
    en_run <= mem_en ? en_run + 4'd1 : 4'd0;
  end

  //////////////////////////////
  // Checks
  //////////////////////////////
  assert property (@(posedge clk) !arst_n |-> !stall && !mem_en)
    else report_mismatch("stall or mem_en high during reset");
  assert property (@(posedge clk) $rose(arst_n) |-> !stall && !mem_en)
    else report_mismatch("stall or mem_en high after reset");

  // Grant held low keeps the fill waiting.
  assert property (@(posedge clk) disable iff (!arst_n) stall && !mem_grant |-> !mem_en)
    else report_mismatch("mem_en high without grant");
  assert property (@(posedge clk) disable iff (!arst_n) stall && !mem_grant |=> stall)
    else report_mismatch("stall fell while grant was low");

  // Exactly eight addresses per burst, from the line base upward.
  assert property (@(posedge clk) disable iff (!arst_n) mem_en |-> en_run < 4'd8)
    else report_mismatch("mem_en high for more than eight cycles");
  assert property (@(posedge clk) disable iff (!arst_n) $fell(mem_en) |-> en_run == 4'd8)
    else report_mismatch("mem_en burst shorter than eight cycles");
  assert property (@(posedge clk) disable iff (!arst_n)
    $rose(mem_en) |-> mem_addr == {req.addr[addr_w-1:offset_w], {offset_w{1'b0}}})
    else report_mismatch("mem_addr does not start at the line base");
  assert property (@(posedge clk) disable iff (!arst_n)
    mem_en && $past(mem_en) |-> mem_addr == $past(mem_addr) + 16'd2)
    else report_mismatch("mem_addr did not step by 2");

  // Misses stall one cycle later, hits never do.
  assert property (@(posedge clk) disable iff (!arst_n) req.valid && !hit && !stall |=> stall)
    else report_mismatch("miss did not raise stall");
  assert property (@(posedge clk) disable iff (!arst_n)
    req.valid && hit && !stall |=> !stall && !mem_en)
    else report_mismatch("hit raised stall or mem_en");
  assert property (@(posedge clk) disable iff (!arst_n) $fell(stall) |-> hit)
    else report_mismatch("held request missed after the fill");

  // Data and model agreement.
  assert property (@(posedge clk) disable iff (!arst_n)
    req.valid && hit |-> rd_data == mem_word({req.addr[addr_w-1:1], 1'b0}))
    else report_mismatch("rd_data differs from the memory word");
  assert property (@(posedge clk) disable iff (!arst_n) pred_valid |-> hit == pred_hit)
    else report_mismatch("hit differs from the reference model");

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  initial begin
    void'($urandom(8690));
    arst_n      = 1'b1;
    req         = '0;
    grant_delay = 0;
    pred_valid  = 1'b0;
    pred_hit    = 1'b0;
    for (int s = 0; s < num_sets; s++) begin
      ref_valid[s][0] = 1'b0;
      ref_valid[s][1] = 1'b0;
      ref_lru_way[s]  = 1'b0;
    end
    #1 arst_n = 1'b0;
    repeat (8) @(posedge clk);
    #1 arst_n = 1'b1;

    grant_delay = 6;  // First miss waits on a late grant.
    do_read(16'h4a30);
    grant_delay = 0;
    for (int w = 0; w < words_per_line; w++) begin
      do_read(16'h4a30 + 16'(2 * w));  // Whole line, all hits.
    end

    // Two lines in set 9, touch the first, then evict with a third.
    do_read(line_addr(6'd1, 6'd9, 3'd0));
    do_read(line_addr(6'd2, 6'd9, 3'd3));
    do_read(line_addr(6'd1, 6'd9, 3'd5));
    do_read(line_addr(6'd3, 6'd9, 3'd1));
    do_read(line_addr(6'd1, 6'd9, 3'd2));  // Still present.
    do_read(line_addr(6'd2, 6'd9, 3'd7));  // Was the victim.

    repeat (60) begin
      grant_delay = int'($urandom_range(0, 4));
      do_read(line_addr(tag_w'($urandom_range(0, 3)), index_w'(20 + $urandom_range(0, 2)),
                        word_w'($urandom_range(0, 7))));
    end

    req.valid = 1'b0;
    repeat (2) @(posedge clk);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
logic/cache_pkg.sv
logic/tag_lookup.sv
logic/miss_fill_ctrl.sv
logic/line_store.sv
logic/cache_top.sv
dv/cache_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := cache_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf $(OBJ_DIR)
